/* lc3b_types.sv */
package lc3b_types;

// #########################################################################
// word and instruction field types
// #########################################################################

typedef logic [15:0] lc3b_word;     // data word or byte address
typedef logic [2:0]  lc3b_reg;      // register number r0 to r7
typedef logic [2:0]  lc3b_nzp;      // negative, zero and positive flags in that order
typedef logic [5:0]  lc3b_offset6;  // signed word offset of ldr and str
typedef logic [8:0]  lc3b_offset9;  // signed word offset of br

// #########################################################################
// opcodes and alu operations
// #########################################################################

// opcode field ir[15:12] with the isa encodings
// the unnamed codes still fit the type and run as no-ops
typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
    alu_add,   // a + b
    alu_and,   // a & b
    alu_not,   // ~a, b is ignored
    alu_pass   // b straight through
} lc3b_aluop;

endpackage : lc3b_types

/* fetch.sv */
`timescale 1ns/10ps

module fetch import lc3b_types::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic     clk,
    input  logic     rst_n,
    // instruction port toward the arbiter
    output logic     instr_read,
    output lc3b_word instr_address,
    input  logic     instr_resp,
    input  lc3b_word instr_rdata,
    // buffered instruction handed to control and datapath
    output logic     ir_valid,
    output lc3b_word ir,
    output lc3b_word ir_pc,
    input  logic     ir_take,
    input  logic     redirect,
    input  lc3b_word redirect_pc
);

lc3b_word pc;         // address of the fetch in flight, or of the next one
logic     req;        // a fetch sits on the instruction port
logic     buf_valid;  // buffer holds an instruction that control has not retired
lc3b_word buf_ir;
lc3b_word buf_pc;     // address the buffered word came from, base of br targets

assign instr_read    = req;
assign instr_address = pc;   // pc only moves when no fetch is waiting
assign ir_valid      = buf_valid;
assign ir            = buf_ir;
assign ir_pc         = buf_pc;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc        <= RESET_PC;
        req       <= 1'b1;   // the first fetch leaves as soon as reset lifts
        buf_valid <= 1'b0;
    end else begin
        if (ir_take || redirect) begin
            buf_valid <= 1'b0;   // retired or flushed, either way the slot frees up
        end
        if (redirect) begin
            // a branch only redirects from a full buffer, so no fetch is waiting
            pc  <= redirect_pc;
            req <= 1'b1;
        end else if (req && instr_resp) begin
            buf_valid <= 1'b1;
            buf_ir    <= instr_rdata;
            buf_pc    <= pc;
            pc        <= pc + 16'd2;
            req       <= 1'b0;   // buffer is full, wait for control
        end else if (ir_take) begin
            req <= 1'b1;   // slot drained so prefetch the next word
        end
    end
end

// the arbiter and memory see one address per fetch even across a redirect
property p_fetch_addr_stable;
    @(posedge clk) disable iff (!rst_n)
        (instr_read && !instr_resp) |=> (instr_read && $stable(instr_address));
endproperty

a_fetch_addr_stable : assert property (p_fetch_addr_stable)
    else $error("fetch: instr_address moved before instr_resp");

endmodule : fetch

/* control.sv */
`timescale 1ns/10ps

module control import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ir_valid,
    input  lc3b_opcode opcode,
    input  logic       branch_enable,
    input  logic       mem_resp,
    output logic       ir_take,
    output logic       load_regfile,
    output logic       load_cc,
    output lc3b_aluop  aluop,
    output logic       regfile_sel_mem,
    output logic       mem_read,
    output logic       mem_write,
    output logic       redirect
);

typedef enum logic [1:0] {
    s_idle,      // waiting for fetch to fill the buffer
    s_execute,   // decode and finish everything that needs no memory
    s_load,      // ldr waits on the data port
    s_store      // str waits on the data port
} state_t;

state_t state;
state_t next_state;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= s_idle;
    end else begin
        state <= next_state;
    end
end

// the alu function only matters while an alu op is in s_execute
always_comb begin
    case (opcode)
        op_add:  aluop = alu_add;
        op_and:  aluop = alu_and;
        op_not:  aluop = alu_not;
        default: aluop = alu_pass;
    endcase
end

always_comb begin
    next_state      = state;
    ir_take         = 1'b0;
    load_regfile    = 1'b0;
    load_cc         = 1'b0;
    regfile_sel_mem = 1'b0;
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    redirect        = 1'b0;
    case (state)
        s_idle: begin
            if (ir_valid) begin
                next_state = s_execute;   // buffer only empties through ir_take or redirect
            end
        end
        s_execute: begin
            case (opcode)
                op_add, op_and, op_not: begin
                    load_regfile = 1'b1;
                    load_cc      = 1'b1;
                    ir_take      = 1'b1;
                    next_state   = s_idle;
                end
                op_br: begin
                    redirect   = branch_enable;   // fetch flushes and restarts at the target
                    ir_take    = 1'b1;
                    next_state = s_idle;
                end
                op_ldr:  next_state = s_load;
                op_str:  next_state = s_store;
                default: begin
                    ir_take    = 1'b1;   // anything else retires without effect
                    next_state = s_idle;
                end
            endcase
        end
        s_load: begin
            mem_read = 1'b1;   // held until the arbiter routes the response here
            if (mem_resp) begin
                regfile_sel_mem = 1'b1;
                load_regfile    = 1'b1;
                load_cc         = 1'b1;   // ldr sets nzp from the loaded word
                ir_take         = 1'b1;
                next_state      = s_idle;
            end
        end
        s_store: begin
            mem_write = 1'b1;
            if (mem_resp) begin
                ir_take    = 1'b1;
                next_state = s_idle;
            end
        end
        default: next_state = s_idle;
    endcase
end

// the data port carries one kind of access at a time
a_no_read_write : assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write))
    else $error("control: mem_read and mem_write high together");

endmodule : control

/* datapath.sv */
`timescale 1ns/10ps

module datapath import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_word   ir,
    input  lc3b_word   ir_pc,
    input  logic       load_regfile,
    input  logic       load_cc,
    input  lc3b_aluop  aluop,
    input  logic       regfile_sel_mem,
    input  lc3b_word   mem_rdata,
    output lc3b_opcode opcode,
    output logic       branch_enable,
    output lc3b_word   mem_address,
    output lc3b_word   mem_wdata,
    output lc3b_word   redirect_pc
);

// #########################################################################
// instruction fields
// #########################################################################

lc3b_reg     dest;       // dr of alu ops and ldr, sr of str
lc3b_reg     sr1;        // first alu source, also base register of ldr and str
lc3b_reg     sr2;
lc3b_nzp     br_mask;    // condition mask of br, same bits as dest
logic        imm_sel;    // ir[5] picks imm5 over sr2
lc3b_word    imm5_sext;
lc3b_offset6 offset6;
lc3b_offset9 offset9;

assign opcode    = lc3b_opcode'(ir[15:12]);
assign dest      = ir[11:9];
assign br_mask   = ir[11:9];
assign sr1       = ir[8:6];
assign sr2       = ir[2:0];
assign imm_sel   = ir[5];
assign imm5_sext = {{11{ir[4]}}, ir[4:0]};
assign offset6   = ir[5:0];
assign offset9   = ir[8:0];

// #########################################################################
// register file, alu and condition codes
// #########################################################################

lc3b_word regs [8];
lc3b_nzp  nzp;
lc3b_word sr1_out;
lc3b_word alu_b;
lc3b_word alu_out;
lc3b_word regfile_in;
lc3b_nzp  cc_in;

assign sr1_out    = regs[sr1];
assign alu_b      = imm_sel ? imm5_sext : regs[sr2];
assign regfile_in = regfile_sel_mem ? mem_rdata : alu_out;   // load data or alu result

always_comb begin
    case (aluop)
        alu_add:  alu_out = sr1_out + alu_b;
        alu_and:  alu_out = sr1_out & alu_b;
        alu_not:  alu_out = ~sr1_out;
        alu_pass: alu_out = alu_b;
        default:  alu_out = alu_b;
    endcase
end

// the flags follow whatever is being written back
always_comb begin
    if (regfile_in[15]) begin
        cc_in = 3'b100;
    end else if (regfile_in == 16'h0000) begin
        cc_in = 3'b010;
    end else begin
        cc_in = 3'b001;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'h0000;
        end
        nzp <= 3'b010;   // all registers read zero, so the flags say zero too
    end else begin
        if (load_regfile) begin
            regs[dest] <= regfile_in;
        end
        if (load_cc) begin
            nzp <= cc_in;
        end
    end
end

// #########################################################################
// addresses and branch decision
// #########################################################################

// offsets count words, so shift left once to get bytes
assign mem_address   = sr1_out + {{9{offset6[5]}}, offset6, 1'b0};
assign mem_wdata     = regs[dest];   // str source register
assign redirect_pc   = ir_pc + 16'd2 + {{6{offset9[8]}}, offset9, 1'b0};
assign branch_enable = |(br_mask & nzp);   // control only looks at it for br

endmodule : datapath

/* mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    // instruction port from fetch
    input  logic       instr_read,
    input  lc3b_word   instr_address,
    output logic       instr_resp,
    output lc3b_word   instr_rdata,
    // data port from control and datapath
    input  logic       mem_read,
    input  logic       mem_write,
    input  lc3b_word   mem_address,
    input  lc3b_word   mem_wdata,
    output logic       mem_resp,
    output lc3b_word   mem_rdata,
    // the one physical memory port
    output logic       pmem_read,
    output logic       pmem_write,
    output lc3b_word   pmem_address,
    output lc3b_word   pmem_wdata,
    output logic [1:0] pmem_byte_enable,
    input  logic       pmem_resp,
    input  lc3b_word   pmem_rdata
);

typedef enum logic [1:0] {
    own_none,
    own_data,
    own_instr
} owner_t;

owner_t owner;   // port holding an access in flight, registered
owner_t grant;   // port driving pmem this cycle

// an idle port grants at once, data before instruction
always_comb begin
    grant = owner;
    if (owner == own_none) begin
        if (mem_read || mem_write) begin
            grant = own_data;
        end else if (instr_read) begin
            grant = own_instr;
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        owner <= own_none;
    end else if (pmem_resp) begin
        owner <= own_none;   // free again on the edge after the response
    end else begin
        owner <= grant;
    end
end

always_comb begin
    pmem_read    = 1'b0;
    pmem_write   = 1'b0;
    pmem_address = instr_address;
    case (grant)
        own_data: begin
            pmem_read    = mem_read;
            pmem_write   = mem_write;
            pmem_address = mem_address;
        end
        own_instr: pmem_read = instr_read;
        default:   pmem_read = 1'b0;
    endcase
end

assign pmem_wdata       = mem_wdata;   // only fetch reads, so write data is always data side
assign pmem_byte_enable = 2'b11;       // word accesses only
assign mem_resp         = pmem_resp && (grant == own_data);
assign instr_resp       = pmem_resp && (grant == own_instr);
assign mem_rdata        = pmem_rdata;
assign instr_rdata      = pmem_rdata;

// a granted port keeps pmem until the memory answers, even if data asks meanwhile
a_hold_grant : assert property (@(posedge clk) disable iff (!rst_n)
    (grant != own_none && !pmem_resp) |=> (grant == $past(grant)))
    else $error("arbiter: owner changed before pmem_resp");

// each response lands on exactly one port, and that port is still asking
a_resp_owner : assert property (@(posedge clk) disable iff (!rst_n)
    pmem_resp |-> $onehot({mem_resp && (mem_read || mem_write), instr_resp && instr_read}))
    else $error("arbiter: pmem_resp not routed to a requesting owner");

endmodule : mem_arbiter

/* mp3.sv */
`timescale 1ns/10ps

module mp3 import lc3b_types::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pmem_resp,
    input  lc3b_word   pmem_rdata,
    output logic       pmem_read,
    output logic       pmem_write,
    output logic [1:0] pmem_byte_enable,
    output lc3b_word   pmem_address,
    output lc3b_word   pmem_wdata
);

// every wire is named after the ports it joins
// instruction port between fetch and the arbiter
logic       instr_read;
lc3b_word   instr_address;
logic       instr_resp;
lc3b_word   instr_rdata;

// fetch buffer and redirect
logic       ir_valid;
lc3b_word   ir;
lc3b_word   ir_pc;
logic       ir_take;
logic       redirect;
lc3b_word   redirect_pc;

// control strobes into the datapath
lc3b_opcode opcode;
logic       branch_enable;
logic       load_regfile;
logic       load_cc;
lc3b_aluop  aluop;
logic       regfile_sel_mem;

// data port toward the arbiter
logic       mem_read;
logic       mem_write;
lc3b_word   mem_address;
lc3b_word   mem_wdata;
logic       mem_resp;
lc3b_word   mem_rdata;

fetch #(
    .RESET_PC(RESET_PC)
) fetch_module (.*);

control control_module (.*);

datapath datapath_module (.*);

mem_arbiter arbiter_module (.*);   // sole driver of the pmem outputs

endmodule : mp3

/* pmem_model.sv */
`timescale 1ns/10ps

module pmem_model import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pmem_read,
    input  logic       pmem_write,
    input  lc3b_word   pmem_address,
    input  lc3b_word   pmem_wdata,
    output logic       pmem_resp,
    output lc3b_word   pmem_rdata
);

lc3b_word mem [32768];    // 64k bytes held as words, indexed by address bits 15 to 1
lc3b_word log_addr [$];   // every completed write, oldest first
lc3b_word log_data [$];
integer   seed;
logic     busy;           // a request has been seen and its answer is pending
int       wait_left;      // cycles until that answer

initial begin
    seed       = 39583;
    busy       = 1'b0;
    wait_left  = 0;
    pmem_resp  = 1'b0;
    pmem_rdata = 16'h0000;
    // each word differs from every other so a stray read shows up
    for (int i = 0; i < 32768; i++) begin
        mem[i] = lc3b_word'({i[14:0], 1'b0}) ^ 16'hc3a5;
    end
end

// the testbench places the program image through this task
task automatic load_word(input lc3b_word addr, input lc3b_word data);
    mem[addr[15:1]] = data;
endtask

// ############################################################################
// response timing, all outputs move on the falling edge
// ############################################################################

always @(negedge clk) begin
    if (!rst_n) begin
        busy      = 1'b0;
        wait_left = 0;
        pmem_resp <= 1'b0;
    end else begin
        pmem_resp <= 1'b0;   // the answer is a single cycle pulse
        if (busy) begin
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                busy = 1'b0;
                pmem_resp <= 1'b1;
                if (pmem_write) begin
                    mem[pmem_address[15:1]] = pmem_wdata;
                    log_addr.push_back(pmem_address);
                    log_data.push_back(pmem_wdata);
                end else begin
                    pmem_rdata <= mem[pmem_address[15:1]];
                end
            end
        end else if (pmem_read || pmem_write) begin
            busy      = 1'b1;
            wait_left = 1 + ($unsigned($random(seed)) % 4);   // 1 to 4 cycles
        end
    end
end

endmodule : pmem_model

/* mp3_tb.sv */
`timescale 1ns/10ps

module mp3_tb
    import lc3b_types::*;
();

localparam lc3b_word RESET_PC      = 16'h0040;
localparam lc3b_word SKIP_ADDR     = 16'h001a;                     // str r1 behind the brz
localparam lc3b_word BRZ_TARGET    = RESET_PC + 16'd24 + 16'd2 + 16'd2;   // word 12, offset 1
localparam lc3b_word LOOP_ADDR     = RESET_PC + 16'd32;            // br to itself at word 16
localparam int       STORE_TIMEOUT = 2000;
localparam int       LOOP_CYCLES   = 60;

logic       clk;
logic       rst_n;
logic       pmem_resp;
lc3b_word   pmem_rdata;
logic       pmem_read;
logic       pmem_write;
logic [1:0] pmem_byte_enable;
lc3b_word   pmem_address;
lc3b_word   pmem_wdata;

lc3b_word program_words [17];
lc3b_word exp_addr [$];        // stores still to come, in program order
lc3b_word exp_data [$];
lc3b_word store_addr [$];      // the whole expected store list, kept for the write log
lc3b_word store_data [$];
logic     seen_first_read;
logic     seen_target_read;
int       loop_reads;          // answered fetches of the self branch
logic     pending;             // a request was waiting at the last edge
logic     held_read;
logic     held_write;
lc3b_word held_address;
lc3b_word held_wdata;

mp3 #(.RESET_PC(RESET_PC)) dut_i (.*);
pmem_model mem_model_i (.*);

// instruction encoders following the isa field layout
function automatic lc3b_word add_imm(lc3b_reg dr, lc3b_reg sr, int imm);
    return {op_add, dr, sr, 1'b1, imm[4:0]};
endfunction

function automatic lc3b_word and_imm(lc3b_reg dr, lc3b_reg sr, int imm);
    return {op_and, dr, sr, 1'b1, imm[4:0]};
endfunction

function automatic lc3b_word not_reg(lc3b_reg dr, lc3b_reg sr);
    return {op_not, dr, sr, 6'b111111};
endfunction

function automatic lc3b_word ldr_word(lc3b_reg dr, lc3b_reg base, int off);
    return {op_ldr, dr, base, off[5:0]};
endfunction

function automatic lc3b_word str_word(lc3b_reg sr, lc3b_reg base, int off);
    return {op_str, sr, base, off[5:0]};
endfunction

function automatic lc3b_word br_cond(lc3b_nzp mask, int off);
    return {op_br, mask, off[8:0]};
endfunction

task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic expect_store(input lc3b_word addr, input lc3b_word data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    store_addr.push_back(addr);
    store_data.push_back(data);
endtask

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// ############################################################################
// checks on the memory port, sampled at the rising edge
// ############################################################################

a_no_read_write : assert property (@(posedge clk) disable iff (!rst_n)
    !(pmem_read && pmem_write))
    else begin
        $display("Fail at %0t: pmem_write is %b, expected 0 while pmem_read is high",
                 $time, $sampled(pmem_write));
        stop_on_error();
    end

always @(posedge clk) begin
    if (!rst_n) begin
        pending = 1'b0;
    end else begin
        if (pmem_read && !seen_first_read) begin
            seen_first_read = 1'b1;
            assert (pmem_address == RESET_PC) else begin
                $display("Fail at %0t: pmem_address is %h, expected %h", $time,
                         pmem_address, RESET_PC);
                stop_on_error();
            end
        end
        if (pending) begin   // a waiting request must not move
            assert (pmem_address == held_address) else begin
                $display("Fail at %0t: pmem_address is %h, expected %h", $time,
                         pmem_address, held_address);
                stop_on_error();
            end
            assert (pmem_read == held_read && pmem_write == held_write) else begin
                $display("Fail at %0t: pmem_read,pmem_write is %b%b, expected %b%b", $time,
                         pmem_read, pmem_write, held_read, held_write);
                stop_on_error();
            end
            assert (!held_write || pmem_wdata == held_wdata) else begin
                $display("Fail at %0t: pmem_wdata is %h, expected %h", $time,
                         pmem_wdata, held_wdata);
                stop_on_error();
            end
        end
        assert (!pmem_write || pmem_byte_enable == 2'b11) else begin
            $display("Fail at %0t: pmem_byte_enable is %b, expected 11", $time,
                     pmem_byte_enable);
            stop_on_error();
        end
        assert (!(pmem_write && pmem_address == SKIP_ADDR)) else begin
            $display("Fail at %0t: pmem_address is %h, expected any store but %h", $time,
                     pmem_address, SKIP_ADDR);
            stop_on_error();
        end
        if (pmem_resp && pmem_write) begin
            if (exp_addr.size() == 0) begin
                $display("store to %h with data %h after all expected stores",
                         pmem_address, pmem_wdata);
                stop_on_error();
            end else begin
                assert (pmem_address == exp_addr[0]) else begin
                    $display("Fail at %0t: pmem_address is %h, expected %h", $time,
                             pmem_address, exp_addr[0]);
                    stop_on_error();
                end
                assert (pmem_wdata == exp_data[0]) else begin
                    $display("Fail at %0t: pmem_wdata is %h, expected %h", $time,
                             pmem_wdata, exp_data[0]);
                    stop_on_error();
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (pmem_resp && pmem_read && pmem_address == BRZ_TARGET) begin
            seen_target_read = 1'b1;   // fetch restarted where the brz points
        end
        if (pmem_resp && pmem_read && pmem_address == LOOP_ADDR) begin
            loop_reads++;
        end
        pending      = (pmem_read || pmem_write) && !pmem_resp;
        held_read    = pmem_read;
        held_write   = pmem_write;
        held_address = pmem_address;
        held_wdata   = pmem_wdata;
    end
end

// ############################################################################
// program image, expected stores and run control
// ############################################################################

initial begin
    int       cycles;
    lc3b_word r1;
    lc3b_word r2;
    lc3b_word r3;
    lc3b_word r4;
    lc3b_word r5;
    lc3b_word r7;
    rst_n            = 1'b0;
    seen_first_read  = 1'b0;
    seen_target_read = 1'b0;
    loop_reads       = 0;
    pending          = 1'b0;
    @(negedge clk);   // memory fill has run by now
    program_words[0]  = add_imm(1, 0, 7);
    program_words[1]  = add_imm(2, 0, -3);
    program_words[2]  = and_imm(3, 2, 13);
    program_words[3]  = not_reg(4, 1);
    program_words[4]  = str_word(1, 0, 8);
    program_words[5]  = str_word(2, 0, 9);
    program_words[6]  = str_word(3, 0, 10);
    program_words[7]  = str_word(4, 0, 11);
    program_words[8]  = ldr_word(6, 0, 9);    // reads back the word stored from r2
    program_words[9]  = add_imm(7, 6, 5);
    program_words[10] = str_word(7, 0, 12);
    program_words[11] = and_imm(5, 5, 0);     // sets z for the brz
    program_words[12] = br_cond(3'b010, 1);   // taken, jumps over word 13
    program_words[13] = str_word(1, 0, 13);
    program_words[14] = br_cond(3'b100, 1);   // not taken, falls into word 15
    program_words[15] = str_word(5, 0, 14);
    program_words[16] = br_cond(3'b111, -1);
    for (int i = 0; i < 17; i++) begin
        mem_model_i.load_word(RESET_PC + 16'(2 * i), program_words[i]);
    end
    r1 = 16'd0 + 16'd7;
    r2 = 16'd0 - 16'd3;     // imm5 of -3 sign extends to all ones above
    r3 = r2 & 16'd13;
    r4 = ~r1;
    r7 = r2 + 16'd5;        // ldr returns r2 from its store
    r5 = 16'd0 & 16'd0;
    expect_store(16'h0010, r1);   // r0 stays zero so offset times 2 is the address
    expect_store(16'h0012, r2);
    expect_store(16'h0014, r3);
    expect_store(16'h0016, r4);
    expect_store(16'h0018, r7);
    expect_store(16'h001c, r5);
    repeat (7) @(negedge clk);    // reset spans 8 rising edges in total
    rst_n <= 1'b1;                // the memory model still sees reset at this falling edge
    cycles = 0;
    while (exp_addr.size() != 0 && cycles < STORE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (exp_addr.size() != 0) begin
        $display("timeout after %0d cycles with %0d expected stores missing",
                 cycles, exp_addr.size());
        stop_on_error();
    end else begin
        cycles = 0;
        while (cycles < LOOP_CYCLES) begin   // the self branch should spin quietly
            @(negedge clk);
            assert (!pmem_write) else begin
                $display("Fail at %0t: pmem_write is 1, expected 0", $time);
                stop_on_error();
            end
            cycles++;
        end
        // the memory itself must have taken exactly the expected writes
        if (mem_model_i.log_addr.size() != store_addr.size()) begin
            $display("Fail at %0t: write log size is %0d, expected %0d", $time,
                     mem_model_i.log_addr.size(), store_addr.size());
            stop_on_error();
        end
        for (int i = 0; i < store_addr.size(); i++) begin
            if (mem_model_i.log_addr[i] != store_addr[i] ||
                mem_model_i.log_data[i] != store_data[i]) begin
                $display("Fail at %0t: write log entry %0d is %h %h, expected %h %h",
                         $time, i, mem_model_i.log_addr[i], mem_model_i.log_data[i],
                         store_addr[i], store_data[i]);
                stop_on_error();
            end
        end
        if (seen_target_read && loop_reads > 1) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("branch target read seen %0b, self branch fetched %0d times",
                     seen_target_read, loop_reads);
            stop_on_error();
        end
    end
end

endmodule : mp3_tb

/* sim.f */
lc3b_types.sv
fetch.sv
control.sv
datapath.sv
mem_arbiter.sv
mp3.sv
pmem_model.sv
mp3_tb.sv
